// ==== flist.f ====
src/mem_bus_pkg.sv
src/fetch_pkg.sv
src/prefetch_buffer.sv
src/instr_predecode.sv
src/fetch_top.sv
test/imem_model.sv
test/tb_fetch_top.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the fetch front end testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
  --top-module tb_fetch_top -Mdir obj_dir -f flist.f
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

output="$(./obj_dir/Vtb_fetch_top)"
status=$?
echo "$output"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -qx "Finished with no errors" <<< "$output"; then
  exit 0
fi
exit 1

// ==== src/fetch_pkg.sv ====
/*
 * Fetch front end types
 * Instruction word with its parcel view, the length rule for RISC-V
 * compressed instructions and the items passed between fetch stages
 */

`default_nettype none

package fetch_pkg;

  // Low two bits of a parcel that starts a 32-bit instruction
  localparam logic [1:0] FULL_INSTR_TAG = 2'b11;

  // One memory word, seen whole or as two 16-bit parcels
  typedef union packed {
    logic [31:0] word;
    struct packed {
      logic [15:0] hi;  // Upper halfword, at byte address +2
      logic [15:0] lo;  // Lower halfword, at byte address +0
    } parcel;
  } fetch_word_u;

  // Instruction handed from the prefetch buffer to predecode
  typedef struct packed {
    logic [31:0] addr;   // Halfword aligned instruction address
    fetch_word_u instr;  // High parcel is zero for compressed ones
  } fetch_item_t;

  // Predecoded instruction at the fetch output
  typedef struct packed {
    logic [31:0] pc;
    logic [31:0] instr;
    logic        is_compressed;
    logic [31:0] next_pc;
    logic        illegal;
  } decoded_instr_t;

  // A parcel begins a 32-bit instruction only when it carries the tag
  function automatic logic parcel_is_full(logic [15:0] parcel);
    return parcel[1:0] == FULL_INSTR_TAG;
  endfunction

endpackage

`default_nettype wire

// ==== src/fetch_top.sv ====
/*
 * Instruction fetch front end
 * Prefetch buffer toward instruction memory, followed by the predecode
 * register toward the consumer
 */

`timescale 1ns/1ps
`default_nettype none

module fetch_top (
  input  wire logic                   clk,
  input  wire logic                   rst_n,
  input  wire logic                   req_i,
  input  wire logic                   ready_i,
  input  wire logic                   branch_i,       // One-cycle pulse with req_i
  input  wire logic [31:0]            branch_addr_i,  // Halfword aligned target
  output logic                        valid_o,
  output fetch_pkg::decoded_instr_t   instr_o,
  output logic                        busy_o,
  output mem_bus_pkg::imem_req_t      imem_req_o,
  input  wire mem_bus_pkg::imem_rsp_t imem_rsp_i
);

  import fetch_pkg::*;

  logic        fetch_valid;
  logic        fetch_ready;
  fetch_item_t fetch_item;

  prefetch_buffer prefetch_buffer_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .req_i        (req_i),
    .branch_i     (branch_i),
    .branch_addr_i(branch_addr_i),
    .ready_i      (fetch_ready),
    .valid_o      (fetch_valid),
    .item_o       (fetch_item),
    .imem_req_o   (imem_req_o),
    .imem_rsp_i   (imem_rsp_i),
    .busy_o       (busy_o)
  );

  // The branch also empties the predecode register in the same edge
  instr_predecode instr_predecode_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .flush_i   (branch_i),
    .in_valid_i(fetch_valid),
    .in_item_i (fetch_item),
    .in_ready_o(fetch_ready),
    .ready_i   (ready_i),
    .valid_o   (valid_o),
    .instr_o   (instr_o)
  );

endmodule

`default_nettype wire

// ==== src/instr_predecode.sv ====
/*
 * Instruction predecode stage
 * Registers each instruction with its address and marks it compressed or
 * full, with its next sequential address and an illegal flag for an
 * all-zero low parcel. Holds under back-pressure, emptied by a flush
 */

`timescale 1ns/1ps
`default_nettype none

module instr_predecode (
  input  wire logic                   clk,
  input  wire logic                   rst_n,
  input  wire logic                   flush_i,     // Drops the held instruction
  input  wire logic                   in_valid_i,
  input  wire fetch_pkg::fetch_item_t in_item_i,
  output logic                        in_ready_o,
  input  wire logic                   ready_i,     // Consumer takes instr_o
  output logic                        valid_o,
  output fetch_pkg::decoded_instr_t   instr_o
);

  import fetch_pkg::*;

  fetch_word_u    word_in;
  logic           compressed;
  logic           load;       // Input transfer this cycle
  decoded_instr_t dec_d;
  decoded_instr_t instr_q;
  logic           valid_q;

  assign word_in    = in_item_i.instr;
  assign compressed = !parcel_is_full(word_in.parcel.lo);

  // Register is free when empty or when its content leaves this cycle
  assign in_ready_o = !valid_q || ready_i;
  assign load       = in_valid_i && in_ready_o;

  always_comb begin
    dec_d.pc            = in_item_i.addr;
    dec_d.is_compressed = compressed;
    // Compressed ones take only the low parcel, full ones the whole word
    dec_d.instr         = compressed ? {16'h0000, word_in.parcel.lo} : word_in.word;
    dec_d.next_pc       = in_item_i.addr + (compressed ? 32'd2 : 32'd4);
    dec_d.illegal       = (word_in.parcel.lo == 16'h0000);  // Zero parcel is never valid code
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_q <= 1'b0;
    end else if (flush_i) begin
      valid_q <= 1'b0;  // Flush beats a transfer in the same cycle
    end else if (load) begin
      valid_q <= 1'b1;
    end else if (ready_i) begin
      valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (load) begin
      instr_q <= dec_d;
    end
  end

  assign valid_o = valid_q;
  assign instr_o = instr_q;

  // Held output does not move until the consumer takes it
  a_hold_stable : assert property (@(posedge clk) disable iff (!rst_n)
    valid_o && !ready_i && !flush_i |=> valid_o && $stable(instr_o));

endmodule

`default_nettype wire

// ==== src/mem_bus_pkg.sv ====
/*
 * Instruction memory bus types
 * One request word toward memory and one response word back, for a
 * req/gnt/rvalid port with at most one access outstanding
 */

`default_nettype none

package mem_bus_pkg;

  // Request held by the master until the cycle with grant
  typedef struct packed {
    logic        req;   // Access wanted
    logic [31:0] addr;  // Word aligned byte address
  } imem_req_t;

  // Response from memory, rvalid comes one or more cycles after gnt
  typedef struct packed {
    logic        gnt;     // Request taken this cycle
    logic        rvalid;  // Read data valid pulse
    logic [31:0] rdata;   // Read data word
  } imem_rsp_t;

endpackage

`default_nettype wire

// ==== src/prefetch_buffer.sv ====
/*
 * Prefetch buffer
 * Fetches 32-bit words over a req/gnt/rvalid port and realigns them into
 * instructions. The upper halfword of the last word is kept so that
 * compressed instructions and the lower half of a word-straddling
 * instruction are served without fetching the same word again
 */

`timescale 1ns/1ps
`default_nettype none

module prefetch_buffer (
  input  wire logic                   clk,
  input  wire logic                   rst_n,
  input  wire logic                   req_i,          // Consumer wants instructions
  input  wire logic                   branch_i,       // Restart at branch_addr_i
  input  wire logic [31:0]            branch_addr_i,
  input  wire logic                   ready_i,
  output logic                        valid_o,
  output fetch_pkg::fetch_item_t      item_o,
  output mem_bus_pkg::imem_req_t      imem_req_o,
  input  wire mem_bus_pkg::imem_rsp_t imem_rsp_i,
  output logic                        busy_o
);

  import fetch_pkg::*;

  typedef enum logic [1:0] {
    IDLE,
    WAIT_GNT,
    WAIT_RVALID,
    WAIT_ABORTED
  } state_e;

  state_e      state_q, state_d;
  logic        abort_q, abort_d;            // Branch came while the request waited for grant
  logic        straddle_q, straddle_d;      // Access fetches the upper half of an instruction
  logic [31:0] pc_q, pc_d;                  // Address of the next instruction to deliver
  logic [29:0] fetch_word_q, fetch_word_d;  // Word address of the current access
  logic [15:0] hbuf_q, hbuf_d;              // Upper parcel of the last fetched word
  logic [29:0] hbuf_word_q, hbuf_word_d;    // Word that parcel came from
  logic        hbuf_valid_q, hbuf_valid_d;
  logic        out_valid_q, out_valid_d;
  fetch_item_t out_item_q, out_item_d;

  fetch_word_u rdata;
  logic        slot_free;  // Output register is empty after this edge
  logic        hbuf_hit;   // The instruction at pc starts in the buffered parcel

  assign rdata     = imem_rsp_i.rdata;
  assign slot_free = !out_valid_q || ready_i;
  assign hbuf_hit  = hbuf_valid_q && pc_q[1] && (hbuf_word_q == pc_q[31:2]);

  ////////////////////////////////////////////////////////////
  // Fetch FSM and realignment
  ////////////////////////////////////////////////////////////

  always_comb begin
    state_d      = state_q;
    abort_d      = abort_q;
    straddle_d   = straddle_q;
    pc_d         = pc_q;
    fetch_word_d = fetch_word_q;
    hbuf_d       = hbuf_q;
    hbuf_word_d  = hbuf_word_q;
    hbuf_valid_d = hbuf_valid_q;
    out_valid_d  = out_valid_q && !ready_i;  // A transfer empties the slot
    out_item_d   = out_item_q;

    unique case (state_q)
      IDLE: begin
        // New work only starts once the output slot is free
        if (req_i && slot_free && !branch_i) begin
          if (hbuf_hit && !parcel_is_full(hbuf_q)) begin
            // Whole compressed instruction is already buffered and needs no access
            out_valid_d            = 1'b1;
            out_item_d.addr        = pc_q;
            out_item_d.instr.word  = {16'h0000, hbuf_q};
            pc_d                   = pc_q + 32'd2;
          end else begin
            // With the lower half buffered only the following word is missing
            straddle_d   = hbuf_hit;
            fetch_word_d = hbuf_hit ? pc_q[31:2] + 30'd1 : pc_q[31:2];
            state_d      = WAIT_GNT;
          end
        end
      end

      WAIT_GNT: begin
        if (imem_rsp_i.gnt) begin
          state_d = abort_q ? WAIT_ABORTED : WAIT_RVALID;
        end
      end

      WAIT_RVALID: begin
        if (imem_rsp_i.rvalid) begin
          // Every word leaves its upper parcel behind for the next instruction
          hbuf_d          = rdata.parcel.hi;
          hbuf_word_d     = fetch_word_q;
          hbuf_valid_d    = 1'b1;
          state_d         = IDLE;
          out_item_d.addr = pc_q;
          if (straddle_q) begin
            // Splice the buffered lower half with the new word's low parcel
            out_valid_d           = 1'b1;
            out_item_d.instr.word = {rdata.parcel.lo, hbuf_q};
            pc_d                  = pc_q + 32'd4;
          end else if (!pc_q[1]) begin
            out_valid_d = 1'b1;
            if (parcel_is_full(rdata.parcel.lo)) begin
              out_item_d.instr = rdata;  // Aligned full instruction
              pc_d             = pc_q + 32'd4;
            end else begin
              out_item_d.instr.word = {16'h0000, rdata.parcel.lo};
              pc_d                  = pc_q + 32'd2;
            end
          end else if (!parcel_is_full(rdata.parcel.hi)) begin
            out_valid_d           = 1'b1;
            out_item_d.instr.word = {16'h0000, rdata.parcel.hi};
            pc_d                  = pc_q + 32'd2;
          end else begin
            // Full instruction starts in the upper parcel so the next word is fetched
            straddle_d   = 1'b1;
            fetch_word_d = fetch_word_q + 30'd1;
            state_d      = WAIT_GNT;
          end
        end
      end

      WAIT_ABORTED: begin
        if (imem_rsp_i.rvalid) begin
          state_d = IDLE;  // Data of the old stream is dropped
          abort_d = 1'b0;
        end
      end

      default: state_d = IDLE;
    endcase

    // A branch restarts the stream whatever the access is doing
    if (branch_i) begin
      pc_d         = branch_addr_i;
      hbuf_valid_d = 1'b0;
      out_valid_d  = 1'b0;
      if (state_q == WAIT_GNT) begin
        // The request cannot be withdrawn before grant and is marked stale
        abort_d = 1'b1;
        if (imem_rsp_i.gnt) begin
          state_d = WAIT_ABORTED;
        end
      end else if (state_q == WAIT_RVALID) begin
        state_d = imem_rsp_i.rvalid ? IDLE : WAIT_ABORTED;
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Registers
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q      <= IDLE;
      abort_q      <= 1'b0;
      straddle_q   <= 1'b0;
      pc_q         <= 32'h0;
      fetch_word_q <= 30'h0;
      hbuf_valid_q <= 1'b0;
      out_valid_q  <= 1'b0;
    end else begin
      state_q      <= state_d;
      abort_q      <= abort_d;
      straddle_q   <= straddle_d;
      pc_q         <= pc_d;
      fetch_word_q <= fetch_word_d;
      hbuf_valid_q <= hbuf_valid_d;
      out_valid_q  <= out_valid_d;
    end
  end

  // Parcel buffer and output item data
  always_ff @(posedge clk) begin
    hbuf_q      <= hbuf_d;
    hbuf_word_q <= hbuf_word_d;
    out_item_q  <= out_item_d;
  end

  assign imem_req_o.req  = (state_q == WAIT_GNT);  // Registered and thus stable until grant
  assign imem_req_o.addr = {fetch_word_q, 2'b00};
  assign valid_o         = out_valid_q;
  assign item_o          = out_item_q;
  assign busy_o          = (state_q != IDLE);

  ////////////////////////////////////////////////////////////
  // Assertions
  ////////////////////////////////////////////////////////////

  // A live request fetches the word at pc or the one after it for an upper half
  a_req_word : assert property (@(posedge clk) disable iff (!rst_n)
    imem_req_o.req && !abort_q |->
      imem_req_o.addr == {pc_q[31:2] + 30'(straddle_q), 2'b00});

  // Request and address hold until the grant cycle
  a_req_stable : assert property (@(posedge clk) disable iff (!rst_n)
    imem_req_o.req && !imem_rsp_i.gnt |=> imem_req_o.req && $stable(imem_req_o.addr));

  a_out_stable : assert property (@(posedge clk) disable iff (!rst_n)
    valid_o && !ready_i && !branch_i |=> valid_o && $stable(item_o));

endmodule

`default_nettype wire

// ==== test/imem_model.sv ====
/*
 * Behavioral instruction memory
 * Word image on a req/gnt/rvalid port with random grant and read latency,
 * at most one access open at a time
 */

`timescale 1ns/1ps
`default_nettype none

module imem_model (
  input  wire logic                   clk,
  input  wire logic                   rst_n,
  input  wire mem_bus_pkg::imem_req_t imem_req_i,
  output mem_bus_pkg::imem_rsp_t      imem_rsp_o
);

  localparam int MEM_WORDS = 256;

  logic [31:0] mem [MEM_WORDS];  // Loaded by the testbench at time zero

  logic        gnt_en;    // Memory takes a request this cycle
  logic        gnt;
  logic        pending;   // Granted access still waiting for its data
  logic [1:0]  delay;     // Cycles left before rvalid
  logic [7:0]  word_idx;  // Word of the granted access, image wraps at 1 KiB
  logic        rvalid_q;
  logic [31:0] rdata_q;

  // No second grant while an access is open
  assign gnt        = imem_req_i.req && gnt_en && !pending;
  assign imem_rsp_o = {gnt, rvalid_q, rdata_q};

  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      gnt_en   <= 1'b0;
      pending  <= 1'b0;
      delay    <= 2'd0;
      word_idx <= 8'd0;
      rvalid_q <= 1'b0;
      rdata_q  <= 32'h0;
    end else begin
      gnt_en   <= ($urandom % 4) != 0;  // Grant about three cycles in four
      rvalid_q <= 1'b0;                 // Rvalid is a single-cycle pulse
      if (gnt) begin
        pending  <= 1'b1;
        word_idx <= imem_req_i.addr[9:2];
        delay    <= 2'($urandom % 3);   // Data one to three cycles after grant
      end else if (pending) begin
        if (delay == 2'd0) begin
          pending  <= 1'b0;
          rvalid_q <= 1'b1;
          rdata_q  <= mem[word_idx];
        end else begin
          delay <= delay - 2'd1;
        end
      end
    end
  end

endmodule

`default_nettype wire

// ==== test/tb_fetch_top.sv ====
/*
 * Testbench for the instruction fetch front end
 * Branches to each table entry and collects its instructions under random
 * back-pressure, comparing them with a walk of the memory image
 */

`timescale 1ns/1ps
`default_nettype none

module tb_fetch_top;

  import fetch_pkg::*;
  import mem_bus_pkg::*;

  localparam int          CLK_PERIOD   = 4;
  localparam int          RESET_CYCLES = 10;
  localparam int          MEM_WORDS    = 256;
  localparam logic [31:0] SEED         = 32'hc208e537;

  typedef struct packed {
    logic [31:0] addr;   // Halfword aligned branch target
    int          count;  // Instructions collected from it
  } entry_t;

  localparam int NUM_ENTRIES = 7;
  localparam entry_t STIM_TABLE [NUM_ENTRIES] = '{
    '{32'h0000_0000, 16},  // Run of aligned full instructions
    '{32'h0000_0100, 24},  // Mixed stream with straddles
    '{32'h0000_0142, 20},  // Target in an upper parcel
    '{32'h0000_0206, 16},
    '{32'h0000_0050, 12},  // Passes the zero word at 0x54
    '{32'h0000_0302, 24},
    '{32'h0000_0012, 8}
  };

  logic           clk = 1'b0;
  logic           rst_n;
  logic           req_i;
  logic           ready_i;
  logic           branch_i;
  logic [31:0]    branch_addr_i;
  logic           valid_o;
  decoded_instr_t instr_o;
  logic           busy_o;
  imem_req_t      imem_req;
  imem_rsp_t      imem_rsp;
  logic [31:0]    image [MEM_WORDS];  // Copy of the memory for the reference walk

  always #(CLK_PERIOD / 2) clk = ~clk;

  fetch_top fetch_top_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .req_i        (req_i),
    .ready_i      (ready_i),
    .branch_i     (branch_i),
    .branch_addr_i(branch_addr_i),
    .valid_o      (valid_o),
    .instr_o      (instr_o),
    .busy_o       (busy_o),
    .imem_req_o   (imem_req),
    .imem_rsp_i   (imem_rsp)
  );

  imem_model imem_model_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .imem_req_i(imem_req),
    .imem_rsp_o(imem_rsp)
  );

  ////////////////////////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////////////////////////

  function automatic logic [15:0] parcel_at(input logic [31:0] addr);
    logic [31:0] word;
    word = image[addr[9:2]];
    return addr[1] ? word[31:16] : word[15:0];
  endfunction

  // Length comes from the low parcel and the upper half may lie in the next word
  function automatic decoded_instr_t expect_at(input logic [31:0] pc);
    decoded_instr_t want;
    logic [15:0]    lo;
    logic           full;
    lo                 = parcel_at(pc);
    full               = (lo[1:0] == FULL_INSTR_TAG);
    want.pc            = pc;
    want.instr         = full ? {parcel_at(pc + 32'd2), lo} : {16'h0000, lo};
    want.is_compressed = !full;
    want.next_pc       = pc + (full ? 32'd4 : 32'd2);
    want.illegal       = (lo == 16'h0000);
    return want;
  endfunction

  function automatic logic random_ready();
    return ($urandom % 3) != 0;  // Consumer stalls about one cycle in three
  endfunction

  ////////////////////////////////////////////////////////////
  // Checks
  ////////////////////////////////////////////////////////////

  task automatic fail_run(input string line);
    $display("%s", line);
    $display("Finished with errors");
    $fatal(1, "Run stopped at the first error");
  endtask

  task automatic check_instr(input decoded_instr_t got, input decoded_instr_t want);
    if (got !== want) begin
      fail_run({$sformatf("Mismatch at %0t: want pc %h instr %h c %b next %h ill %b,", $time,
                          want.pc, want.instr, want.is_compressed, want.next_pc, want.illegal),
                $sformatf(" got pc %h instr %h c %b next %h ill %b",
                          got.pc, got.instr, got.is_compressed, got.next_pc, got.illegal)});
    end
  endtask

  task automatic check_busy(input logic got, input logic want);
    if (got !== want) begin
      fail_run($sformatf("Mismatch at %0t: busy_o is %b, expected %b", $time, got, want));
    end
  endtask

  task automatic check_valid(input logic got, input logic want);
    if (got !== want) begin
      fail_run($sformatf("Mismatch at %0t: valid_o is %b, expected %b", $time, got, want));
    end
  endtask

  task automatic check_mem_req(input imem_req_t got, input logic want_req);
    if (got.req !== want_req) begin
      fail_run($sformatf("Mismatch at %0t: imem request is %b, expected %b",
                         $time, got.req, want_req));
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////

  // Values read right after the edge are the ones the DUT just sampled
  task automatic run_entry(input logic [31:0] target, input int count);
    logic [31:0]    pc;
    decoded_instr_t want;
    int             taken;
    pc            = target;
    taken         = 0;
    branch_i      <= 1'b1;
    branch_addr_i <= target;
    req_i         <= 1'b1;
    ready_i       <= 1'b0;  // Nothing is taken in the branch cycle
    @(posedge clk);
    branch_i <= 1'b0;
    ready_i  <= random_ready();
    while (taken < count) begin
      @(posedge clk);
      if (valid_o && ready_i) begin
        want = expect_at(pc);
        check_instr(instr_o, want);
        pc    = want.next_pc;
        taken = taken + 1;
      end
      ready_i <= random_ready();
    end
  endtask

  // Final branch drops the old stream and req_i low then lets the fetch go idle
  task automatic stop_stream();
    branch_i      <= 1'b1;
    branch_addr_i <= 32'h0;
    ready_i       <= 1'b0;
    @(posedge clk);
    branch_i <= 1'b0;
    req_i    <= 1'b0;
    @(posedge clk);
    while (busy_o) @(posedge clk);
    repeat (16) begin
      @(posedge clk);
      check_valid(valid_o, 1'b0);
      check_busy(busy_o, 1'b0);
      check_mem_req(imem_req, 1'b0);
    end
  endtask

  function automatic int watchdog_cycles();
    int total;
    total = 0;
    for (int i = 0; i < NUM_ENTRIES; i++) begin
      total = total + STIM_TABLE[3'(i)].count;
    end
    return total * 40;
  endfunction

  initial begin
    #(watchdog_cycles() * CLK_PERIOD);
    fail_run("Timeout: the fetch front end stopped delivering instructions");
  end

  initial begin
    logic [31:0] word;
    void'($urandom(SEED));
    rst_n         = 1'b0;
    req_i         = 1'b0;
    ready_i       = 1'b0;
    branch_i      = 1'b0;
    branch_addr_i = 32'h0;
    for (int i = 0; i < MEM_WORDS; i++) begin
      word = $urandom;
      if (i < 16) begin
        word[1:0] = FULL_INSTR_TAG;     // First 64 bytes hold full instructions only
      end else if (i % 32 == 21) begin
        word = 32'h0;                   // Zero parcels for the illegal flag
      end else if (i % 8 == 3) begin
        word[1:0] = 2'($urandom % 3);   // Compressed low parcel
      end
      image[8'(i)]              = word;
      imem_model_i.mem[8'(i)]   = word;
    end
    repeat (RESET_CYCLES) @(posedge clk);
    check_busy(busy_o, 1'b0);
    check_valid(valid_o, 1'b0);
    check_mem_req(imem_req, 1'b0);
    rst_n <= 1'b1;
    for (int i = 0; i < NUM_ENTRIES; i++) begin
      run_entry(STIM_TABLE[3'(i)].addr, STIM_TABLE[3'(i)].count);
    end
    stop_stream();
    $display("Finished with no errors");
    $finish;
  end

endmodule

`default_nettype wire
